/* build.f */
design/tx_dsc_pkg.sv
design/tx_queue_table.sv
design/doorbell_monitor.sv
design/dsc_reads_fifo.sv
design/fetch_request_gen.sv
design/tx_dsc_fetch_top.sv
tests/tx_dsc_fetch_assertions.sv
tests/tb_tx_dsc_fetch.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall
TOP        = tb_tx_dsc_fetch
FILELIST   = build.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_tx_dsc_fetch.sv */
`timescale 1ns/1ps

module tb_tx_dsc_fetch;

  typedef logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     addr_t;
  typedef logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] ptr_t;
  typedef logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] qid_t;
  typedef logic [tx_dsc_pkg::CNT_WIDTH-1:0]      cnt_t;

  localparam int RING    = 64;
  localparam int TIMEOUT = 200;
  localparam int QUIET   = 60;

  logic  clk;
  logic  rst;
  logic  cfg_wr_en;
  qid_t  cfg_queue_id;
  addr_t cfg_base_addr;
  ptr_t  ring_size;
  logic  tail_wr_en;
  qid_t  tail_queue_id;
  ptr_t  tail_value;
  logic  fetch_req;
  logic  fetch_ack;
  addr_t fetch_addr;
  ptr_t  fetch_nb_dsc;
  qid_t  fetch_queue_id;
  ptr_t  fetch_head;
  cnt_t  ignored_dsc_cnt;
  cnt_t  empty_tail_cnt;
  cnt_t  dsc_cnt;

  // Reference view of the queue table.
  addr_t model_base [tx_dsc_pkg::NB_QUEUES];
  ptr_t  model_tail [tx_dsc_pkg::NB_QUEUES];

  // Requests still expected, oldest first.
  addr_t exp_addr_q [$];
  ptr_t  exp_nb_q   [$];
  qid_t  exp_qid_q  [$];
  ptr_t  exp_head_q [$];

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int served_dsc = 0;

  tx_dsc_fetch_top dut0 (
    .clk             (clk),
    .rst             (rst),
    .cfg_wr_en       (cfg_wr_en),
    .cfg_queue_id    (cfg_queue_id),
    .cfg_base_addr   (cfg_base_addr),
    .ring_size       (ring_size),
    .tail_wr_en      (tail_wr_en),
    .tail_queue_id   (tail_queue_id),
    .tail_value      (tail_value),
    .fetch_req       (fetch_req),
    .fetch_ack       (fetch_ack),
    .fetch_addr      (fetch_addr),
    .fetch_nb_dsc    (fetch_nb_dsc),
    .fetch_queue_id  (fetch_queue_id),
    .fetch_head      (fetch_head),
    .ignored_dsc_cnt (ignored_dsc_cnt),
    .empty_tail_cnt  (empty_tail_cnt),
    .dsc_cnt         (dsc_cnt)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  function automatic addr_t pick_base();
    return {$urandom(), $urandom()} & ~64'h3f;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic configure_queue(input qid_t q, input addr_t base);
    @(posedge clk);
    cfg_wr_en     <= 1'b1;
    cfg_queue_id  <= q;
    cfg_base_addr <= base;
    @(posedge clk);
    cfg_wr_en <= 1'b0;
    model_base[q] = base;
    model_tail[q] = '0;
  endtask

  task automatic ring_doorbell(input qid_t q, input ptr_t t);
    @(posedge clk);
    tail_wr_en    <= 1'b1;
    tail_queue_id <= q;
    tail_value    <= t;
    @(posedge clk);
    tail_wr_en <= 1'b0;
  endtask

  task automatic push_expected(input addr_t a, input ptr_t nb, input qid_t q, input ptr_t h);
    exp_addr_q.push_back(a);
    exp_nb_q.push_back(nb);
    exp_qid_q.push_back(q);
    exp_head_q.push_back(h);
  endtask

  // A range that wraps is split at the end of the ring.
  task automatic predict(input qid_t q, input ptr_t t);
    ptr_t  h;
    addr_t first_addr;
    h = model_tail[q];
    first_addr = model_base[q] + 64'(h) * 64;
    if (t > h) begin
      push_expected(first_addr, t - h, q, h);
    end else if (t != h) begin
      push_expected(first_addr, ptr_t'(RING) - h, q, h);
      if (t != '0) begin
        push_expected(model_base[q], t, q, '0);
      end
    end
    model_tail[q] = t;
  endtask

  //////////////////////////////////////////////////
  // Fetch responder
  //////////////////////////////////////////////////

  task automatic serve_request(input int max_cycles, output bit got, output addr_t a,
                               output ptr_t nb, output qid_t q, output ptr_t h);
    int n;
    got = 1'b0;
    n = 0;
    while (!got && n < max_cycles) begin
      @(posedge clk);
      got = fetch_req;
      n++;
    end
    if (got) begin
      a  = fetch_addr;
      nb = fetch_nb_dsc;
      q  = fetch_queue_id;
      h  = fetch_head;
      fetch_ack <= 1'b1;
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (fetch_req && n < TIMEOUT);
      assert (!fetch_req) else begin
        $display("fetch_req stayed high after fetch_ack was raised");
        errors++;
      end
      fetch_ack <= 1'b0;
    end
  endtask

  task automatic compare_request(input addr_t a, input ptr_t nb, input qid_t q, input ptr_t h);
    assert (exp_addr_q.size() > 0) else begin
      $display("A fetch request arrived that no doorbell accounts for");
      errors++;
    end
    if (exp_addr_q.size() > 0) begin
      check_value("fetch_addr", a, exp_addr_q.pop_front());
      check_value("fetch_nb_dsc", 64'(nb), 64'(exp_nb_q[0]));
      check_value("fetch_queue_id", 64'(q), 64'(exp_qid_q.pop_front()));
      check_value("fetch_head", 64'(h), 64'(exp_head_q.pop_front()));
      served_dsc += int'(exp_nb_q.pop_front());
    end
  endtask

  task automatic drain_expected();
    bit    got;
    addr_t a;
    ptr_t  nb;
    qid_t  q;
    ptr_t  h;
    while (exp_addr_q.size() > 0) begin
      serve_request(TIMEOUT, got, a, nb, q, h);
      assert (got) else begin
        $display("No fetch request arrived before the timeout");
        errors++;
      end
      if (got) begin
        compare_request(a, nb, q, h);
      end else begin
        exp_addr_q.delete();
        exp_nb_q.delete();
        exp_qid_q.delete();
        exp_head_q.delete();
      end
    end
  endtask

  task automatic expect_no_request();
    bit    got;
    addr_t a;
    ptr_t  nb;
    qid_t  q;
    ptr_t  h;
    serve_request(QUIET, got, a, nb, q, h);
    assert (!got) else begin
      $display("A fetch request arrived where none was expected");
      errors++;
    end
  endtask

  task automatic wait_empty_tail(input cnt_t exp);
    int n;
    n = 0;
    while (empty_tail_cnt != exp && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    check_value("empty_tail_cnt", 64'(empty_tail_cnt), 64'(exp));
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err0);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    check_value("fetch_req", 64'(fetch_req), 64'd0);
    check_value("ignored_dsc_cnt", 64'(ignored_dsc_cnt), 64'd0);
    check_value("empty_tail_cnt", 64'(empty_tail_cnt), 64'd0);
    check_value("dsc_cnt", 64'(dsc_cnt), 64'd0);
    finish_test("reset state", err0);
  endtask

  task automatic test_simple_fetch();
    int err0;
    err0 = errors;
    configure_queue(3'd2, pick_base());
    predict(3'd2, 10'd5);
    ring_doorbell(3'd2, 10'd5);
    drain_expected();
    predict(3'd2, 10'd9);
    ring_doorbell(3'd2, 10'd9);
    drain_expected();
    check_value("dsc_cnt", 64'(dsc_cnt), 64'd9);
    finish_test("simple fetch", err0);
  endtask

  task automatic test_wrap_split();
    int err0;
    err0 = errors;
    configure_queue(3'd3, pick_base());
    predict(3'd3, 10'd60);
    ring_doorbell(3'd3, 10'd60);
    drain_expected();
    predict(3'd3, 10'd3);
    ring_doorbell(3'd3, 10'd3);
    drain_expected();
    finish_test("wrap split", err0);
  endtask

  task automatic test_wrap_to_zero();
    int   err0;
    cnt_t empty0;
    err0 = errors;
    configure_queue(3'd1, pick_base());
    predict(3'd1, 10'd60);
    ring_doorbell(3'd1, 10'd60);
    drain_expected();
    predict(3'd1, 10'd0);
    ring_doorbell(3'd1, 10'd0);
    drain_expected();
    // Same tail again, an empty range.
    empty0 = empty_tail_cnt;
    ring_doorbell(3'd1, 10'd0);
    expect_no_request();
    wait_empty_tail(empty0 + 1);
    finish_test("wrap to zero and empty tail", err0);
  endtask

  task automatic test_back_pressure();
    int    err0;
    int    k;
    bit    got;
    addr_t a;
    ptr_t  nb;
    qid_t  q;
    ptr_t  h;
    cnt_t  ign0;
    err0 = errors;
    ign0 = ignored_dsc_cnt;
    for (int i = 4; i < 8; i++) begin
      configure_queue(qid_t'(i), pick_base());
    end
    // Nobody answers the handshake while the doorbells go in.
    for (int i = 0; i < 20; i++) begin
      predict(qid_t'(4 + i % 4), ptr_t'((i / 4 + 1) * 3));
      ring_doorbell(qid_t'(4 + i % 4), ptr_t'((i / 4 + 1) * 3));
    end
    k = 0;
    got = 1'b1;
    while (got && k <= 20) begin
      serve_request(QUIET, got, a, nb, q, h);
      if (got) begin
        compare_request(a, nb, q, h);
        k++;
      end
    end
    exp_addr_q.delete();
    exp_nb_q.delete();
    exp_qid_q.delete();
    exp_head_q.delete();
    assert (k < 20) else begin
      $display("No doorbell was ignored while ack was withheld");
      errors++;
    end
    check_value("ignored_dsc_cnt", 64'(ignored_dsc_cnt - ign0), 64'(20 - k));
    finish_test("back-pressure", err0);
  endtask

  task automatic test_multi_queue();
    int   err0;
    int   sum0;
    cnt_t cnt0;
    qid_t qs [8] = '{3'd0, 3'd1, 3'd6, 3'd0, 3'd1, 3'd6, 3'd0, 3'd1};
    ptr_t ts [8] = '{10'd10, 10'd7, 10'd50, 10'd20, 10'd2, 10'd63, 10'd5, 10'd30};
    err0 = errors;
    configure_queue(3'd0, pick_base());
    configure_queue(3'd1, pick_base());
    configure_queue(3'd6, pick_base());
    sum0 = served_dsc;
    cnt0 = dsc_cnt;
    for (int i = 0; i < 8; i++) begin
      predict(qs[i], ts[i]);
      ring_doorbell(qs[i], ts[i]);
    end
    drain_expected();
    check_value("dsc_cnt", 64'(dsc_cnt - cnt0), 64'(served_dsc - sum0));
    finish_test("multiple queues", err0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int assert_fails;
    void'($urandom(32'h581d_b16b));
    clk           = 1'b0;
    rst           = 1'b1;
    cfg_wr_en     = 1'b0;
    cfg_queue_id  = '0;
    cfg_base_addr = '0;
    ring_size     = ptr_t'(RING);
    tail_wr_en    = 1'b0;
    tail_queue_id = '0;
    tail_value    = '0;
    fetch_ack     = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    test_reset_state();
    test_simple_fetch();
    test_wrap_split();
    test_wrap_to_zero();
    test_back_pressure();
    test_multi_queue();

    assert_fails = int'(dut0.req_gen.handshake_checks.fail_count);
    $display("tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tests/tx_dsc_fetch_assertions.sv */
`timescale 1ns/1ps

module tx_dsc_fetch_assertions (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  fetch_req,
  input  logic                                  fetch_ack,
  input  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     fetch_addr,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] fetch_nb_dsc,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] fetch_queue_id,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] fetch_head
);

  int unsigned fail_count = 0;

  // A request is held until it is acknowledged.
  req_held: assert property (@(posedge clk) disable iff (rst)
    fetch_req && !fetch_ack |=> fetch_req)
    else begin
      fail_count++;
      $error("fetch_req dropped before fetch_ack rose");
    end

  // Request fields do not move while the request is up.
  fields_stable: assert property (@(posedge clk) disable iff (rst)
    fetch_req && $past(fetch_req) |->
      $stable({fetch_addr, fetch_nb_dsc, fetch_queue_id, fetch_head}))
    else begin
      fail_count++;
      $error("fetch fields changed while fetch_req was high");
    end

  // The next request waits for ack to fall.
  no_early_req: assert property (@(posedge clk) disable iff (rst)
    !fetch_req && fetch_ack |=> !fetch_req)
    else begin
      fail_count++;
      $error("fetch_req rose while fetch_ack was still high");
    end

endmodule

bind fetch_request_gen tx_dsc_fetch_assertions handshake_checks (
  .clk            (clk),
  .rst            (rst),
  .fetch_req      (fetch_req),
  .fetch_ack      (fetch_ack),
  .fetch_addr     (fetch_addr),
  .fetch_nb_dsc   (fetch_nb_dsc),
  .fetch_queue_id (fetch_queue_id),
  .fetch_head     (fetch_head)
);

/* design/tx_dsc_fetch_top.sv */
`timescale 1ns/1ps

module tx_dsc_fetch_top (
  input  logic                                  clk,
  input  logic                                  rst,

  // Queue config.
  input  logic                                  cfg_wr_en,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] cfg_queue_id,
  input  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     cfg_base_addr,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] ring_size,

  // Doorbells.
  input  logic                                  tail_wr_en,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] tail_queue_id,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] tail_value,

  // Descriptor fetch requests.
  output logic                                  fetch_req,
  input  logic                                  fetch_ack,
  output logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     fetch_addr,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] fetch_nb_dsc,
  output logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] fetch_queue_id,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] fetch_head,

  // Counters.
  output logic [tx_dsc_pkg::CNT_WIDTH-1:0]      ignored_dsc_cnt,
  output logic [tx_dsc_pkg::CNT_WIDTH-1:0]      empty_tail_cnt,
  output logic [tx_dsc_pkg::CNT_WIDTH-1:0]      dsc_cnt
);

  logic                                  rd_en;
  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] rd_queue_id;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] new_tail;
  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     rd_base;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] rd_head;

  logic                                  push;
  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] push_queue_id;
  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     push_base;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] push_head;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] push_tail;

  logic                                  pop;
  logic                                  valid;
  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] out_queue_id;
  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     out_base;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] out_head;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] out_tail;
  logic                                  alm_full;

  tx_queue_table queue_table (
    .clk           (clk),
    .rst           (rst),
    .cfg_wr_en     (cfg_wr_en),
    .cfg_queue_id  (cfg_queue_id),
    .cfg_base_addr (cfg_base_addr),
    .rd_en         (rd_en),
    .rd_queue_id   (rd_queue_id),
    .new_tail      (new_tail),
    .rd_base       (rd_base),
    .rd_head       (rd_head)
  );

  doorbell_monitor db_monitor (
    .clk             (clk),
    .rst             (rst),
    .tail_wr_en      (tail_wr_en),
    .tail_queue_id   (tail_queue_id),
    .tail_value      (tail_value),
    .fifo_alm_full   (alm_full),
    .rd_en           (rd_en),
    .rd_queue_id     (rd_queue_id),
    .new_tail        (new_tail),
    .rd_base         (rd_base),
    .rd_head         (rd_head),
    .push            (push),
    .push_queue_id   (push_queue_id),
    .push_base       (push_base),
    .push_head       (push_head),
    .push_tail       (push_tail),
    .ignored_dsc_cnt (ignored_dsc_cnt),
    .empty_tail_cnt  (empty_tail_cnt)
  );

  dsc_reads_fifo reads_fifo (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_queue_id (push_queue_id),
    .push_base     (push_base),
    .push_head     (push_head),
    .push_tail     (push_tail),
    .pop           (pop),
    .valid         (valid),
    .out_queue_id  (out_queue_id),
    .out_base      (out_base),
    .out_head      (out_head),
    .out_tail      (out_tail),
    .alm_full      (alm_full)
  );

  fetch_request_gen req_gen (
    .clk            (clk),
    .rst            (rst),
    .ring_size      (ring_size),
    .valid          (valid),
    .out_queue_id   (out_queue_id),
    .out_base       (out_base),
    .out_head       (out_head),
    .out_tail       (out_tail),
    .pop            (pop),
    .fetch_req      (fetch_req),
    .fetch_ack      (fetch_ack),
    .fetch_addr     (fetch_addr),
    .fetch_nb_dsc   (fetch_nb_dsc),
    .fetch_queue_id (fetch_queue_id),
    .fetch_head     (fetch_head),
    .dsc_cnt        (dsc_cnt)
  );

endmodule

/* design/fetch_request_gen.sv */
`timescale 1ns/1ps

module fetch_request_gen (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] ring_size,

  // Pending-read FIFO.
  input  logic                                  valid,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] out_queue_id,
  input  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     out_base,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] out_head,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] out_tail,
  output logic                                  pop,

  // Four-phase fetch handshake.
  output logic                                  fetch_req,
  input  logic                                  fetch_ack,
  output logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     fetch_addr,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] fetch_nb_dsc,
  output logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] fetch_queue_id,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] fetch_head,

  output logic [tx_dsc_pkg::CNT_WIDTH-1:0]      dsc_cnt
);

  tx_dsc_pkg::fetch_state_t state;

  logic                                  has_second;
  logic                                  wraps;
  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     base_q;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] tail_q;

  // Head equal to tail never reaches the FIFO, so this is a true wrap.
  assign wraps = (out_tail <= out_head);

  // Only pop once the previous handshake has fully closed.
  assign pop = (state == tx_dsc_pkg::IDLE) & valid & ~fetch_ack;

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= tx_dsc_pkg::IDLE;
      fetch_req  <= 1'b0;
      has_second <= 1'b0;
      dsc_cnt    <= '0;
    end else begin
      case (state)
        tx_dsc_pkg::IDLE: begin
          if (pop) begin
            fetch_req  <= 1'b1;
            has_second <= wraps & (out_tail != '0);
            state      <= tx_dsc_pkg::REQ_HIGH;
          end
        end
        tx_dsc_pkg::REQ_HIGH: begin
          if (fetch_ack) begin
            fetch_req <= 1'b0;
            dsc_cnt   <= dsc_cnt + tx_dsc_pkg::CNT_WIDTH'(fetch_nb_dsc);
            state     <= tx_dsc_pkg::REQ_LOW;
          end
        end
        tx_dsc_pkg::REQ_LOW: begin
          if (!fetch_ack) begin
            state <= has_second ? tx_dsc_pkg::SECOND_PENDING : tx_dsc_pkg::IDLE;
          end
        end
        tx_dsc_pkg::SECOND_PENDING: begin
          fetch_req  <= 1'b1;
          has_second <= 1'b0;
          state      <= tx_dsc_pkg::REQ_HIGH;
        end
        default: state <= tx_dsc_pkg::IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Request fields
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (pop) begin
      base_q         <= out_base;
      tail_q         <= out_tail;
      fetch_queue_id <= out_queue_id;
      fetch_head     <= out_head;
      fetch_addr     <= out_base + (tx_dsc_pkg::ADDR_WIDTH'(out_head) << tx_dsc_pkg::DSC_SHIFT);
      // First half of a wrap runs to the end of the ring.
      fetch_nb_dsc   <= wraps ? ring_size - out_head : out_tail - out_head;
    end else if (state == tx_dsc_pkg::SECOND_PENDING) begin
      fetch_addr   <= base_q;
      fetch_nb_dsc <= tail_q;
      fetch_head   <= '0;
    end
  end

endmodule

/* design/dsc_reads_fifo.sv */
`timescale 1ns/1ps

module dsc_reads_fifo (
  input  logic                                  clk,
  input  logic                                  rst,

  input  logic                                  push,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] push_queue_id,
  input  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     push_base,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] push_head,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] push_tail,

  // First-word fall-through read side.
  input  logic                                  pop,
  output logic                                  valid,
  output logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] out_queue_id,
  output logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     out_base,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] out_head,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] out_tail,
  output logic                                  alm_full
);

  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] qid_mem  [tx_dsc_pkg::READS_FIFO_DEPTH];
  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     base_mem [tx_dsc_pkg::READS_FIFO_DEPTH];
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] head_mem [tx_dsc_pkg::READS_FIFO_DEPTH];
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] tail_mem [tx_dsc_pkg::READS_FIFO_DEPTH];

  logic [tx_dsc_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [tx_dsc_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [tx_dsc_pkg::FIFO_CNT_WIDTH-1:0] count;
  logic                                  wr_ok;
  logic                                  rd_ok;

  assign wr_ok    = push & (count != tx_dsc_pkg::FIFO_CNT_WIDTH'(tx_dsc_pkg::READS_FIFO_DEPTH));
  assign rd_ok    = pop & valid;
  assign valid    = (count != '0);
  assign alm_full = (count >= tx_dsc_pkg::FIFO_CNT_WIDTH'(tx_dsc_pkg::READS_FIFO_ALM_FULL));

  assign out_queue_id = qid_mem[rd_ptr];
  assign out_base     = base_mem[rd_ptr];
  assign out_head     = head_mem[rd_ptr];
  assign out_tail     = tail_mem[rd_ptr];

  // Pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      count <= count + wr_ok - rd_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      qid_mem[wr_ptr]  <= push_queue_id;
      base_mem[wr_ptr] <= push_base;
      head_mem[wr_ptr] <= push_head;
      tail_mem[wr_ptr] <= push_tail;
    end
  end

endmodule

/* design/doorbell_monitor.sv */
`timescale 1ns/1ps

module doorbell_monitor (
  input  logic                                  clk,
  input  logic                                  rst,

  // Doorbell strobe from the CPU.
  input  logic                                  tail_wr_en,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] tail_queue_id,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] tail_value,
  input  logic                                  fifo_alm_full,

  // Queue table port.
  output logic                                  rd_en,
  output logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] rd_queue_id,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] new_tail,
  input  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     rd_base,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] rd_head,

  // Push side of the pending-read FIFO.
  output logic                                  push,
  output logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] push_queue_id,
  output logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     push_base,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] push_head,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] push_tail,

  // Counters.
  output logic [tx_dsc_pkg::CNT_WIDTH-1:0]      ignored_dsc_cnt,
  output logic [tx_dsc_pkg::CNT_WIDTH-1:0]      empty_tail_cnt
);

  logic                                  rd_valid_q;
  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] queue_id_q;
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] tail_q;

  // Doorbells are dropped while the FIFO is almost full.
  assign rd_en       = tail_wr_en & ~fifo_alm_full;
  assign rd_queue_id = tail_queue_id;
  assign new_tail    = tail_value;

  //////////////////////////////////////////////////
  // Table read stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q      <= 1'b0;
      ignored_dsc_cnt <= '0;
    end else begin
      rd_valid_q <= rd_en;
      if (tail_wr_en & fifo_alm_full) begin
        ignored_dsc_cnt <= ignored_dsc_cnt + 1'b1;
      end
    end
  end

  // Id and tail travel alongside the table read.
  always_ff @(posedge clk) begin
    queue_id_q <= tail_queue_id;
    tail_q     <= tail_value;
  end

  //////////////////////////////////////////////////
  // Compare stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      push           <= 1'b0;
      empty_tail_cnt <= '0;
    end else begin
      push <= rd_valid_q & (rd_head != tail_q);
      if (rd_valid_q & (rd_head == tail_q)) begin
        empty_tail_cnt <= empty_tail_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    push_queue_id <= queue_id_q;
    push_base     <= rd_base;
    push_head     <= rd_head;
    push_tail     <= tail_q;
  end

endmodule

/* design/tx_queue_table.sv */
`timescale 1ns/1ps

module tx_queue_table (
  input  logic                                  clk,
  input  logic                                  rst,

  // Config writes.
  input  logic                                  cfg_wr_en,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] cfg_queue_id,
  input  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     cfg_base_addr,

  // Doorbell read port, which also stores the new tail.
  input  logic                                  rd_en,
  input  logic [tx_dsc_pkg::QUEUE_ID_WIDTH-1:0] rd_queue_id,
  input  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] new_tail,
  output logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     rd_base,
  output logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] rd_head
);

  logic [tx_dsc_pkg::ADDR_WIDTH-1:0]     base_mem [tx_dsc_pkg::NB_QUEUES];
  logic [tx_dsc_pkg::RING_PTR_WIDTH-1:0] tail_mem [tx_dsc_pkg::NB_QUEUES];

  // Table update.
  // A config write in the same cycle as a doorbell on that queue wins.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < tx_dsc_pkg::NB_QUEUES; i++) begin
        base_mem[i] <= '0;
        tail_mem[i] <= '0;
      end
    end else begin
      if (rd_en) begin
        tail_mem[rd_queue_id] <= new_tail;
      end
      if (cfg_wr_en) begin
        base_mem[cfg_queue_id] <= cfg_base_addr;
        tail_mem[cfg_queue_id] <= '0;
      end
    end
  end

  // Read port returns the values held before this cycle's write.
  // The old tail becomes the head of the new range.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_base <= base_mem[rd_queue_id];
      rd_head <= tail_mem[rd_queue_id];
    end
  end

endmodule

/* design/tx_dsc_pkg.sv */
package tx_dsc_pkg;

  //////////////////////////////////////////////////
  // Queue table geometry
  //////////////////////////////////////////////////

  localparam int NB_QUEUES      = 8;
  localparam int QUEUE_ID_WIDTH = 3;

  // Wide enough to hold a ring size of 512.
  localparam int RING_PTR_WIDTH = 10;
  localparam int ADDR_WIDTH     = 64;

  // One descriptor is 64 bytes.
  localparam int DSC_SHIFT = 6;
  localparam int CNT_WIDTH = 32;

  //////////////////////////////////////////////////
  // Pending-read FIFO
  //////////////////////////////////////////////////

  localparam int READS_FIFO_DEPTH = 16;

  // Leaves room for the reads still in the doorbell pipeline.
  localparam int READS_FIFO_ALM_FULL = 12;
  localparam int FIFO_PTR_WIDTH      = $clog2(READS_FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH      = FIFO_PTR_WIDTH + 1;

  // Fetch request generator states.
  typedef enum logic [1:0] {
    IDLE,
    REQ_HIGH,
    REQ_LOW,
    SECOND_PENDING
  } fetch_state_t;

endpackage
